// ==== filelist.f ====
rtl/lanePkg.sv
rtl/exStageBus.sv
rtl/bypassBus.sv
rtl/laneRegFile.sv
rtl/laneDataMem.sv
rtl/laneExec1.sv
rtl/laneExec2.sv
rtl/laneTop.sv
bench/laneModelPkg.sv
bench/laneBench.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the lane testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/1ps \
	--top-module laneBench \
	-Mdir build \
	-f filelist.f

./build/VlaneBench > sim.log
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== bench/laneBench.sv ====
module laneBench import lanePkg::*, laneModelPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int memDepth = 256;
	localparam int resetCycles = 2;
	localparam int directedOps = regCount;	// One zero read per register
	localparam int randomOps = 400;
	localparam int cycleLimit = resetCycles + directedOps + randomOps + 20;

	logic clock;
	logic reset;
	logic issueValid;
	logic [cmdWidth-1:0] issueCmd;
	logic [ixtWidth-1:0] issueIxt;
	regIdT issueRs;
	regIdT issueRt;
	regIdT issueRm;
	laneWordT issueImm;
	logic flush;
	logic wbValid;
	regIdT wbId;
	laneWordT wbValue;
	logic srT;

	logic [15:0] lfsrState;
	int cycle;	// Rising edges seen
	int wbErrors;	// Missing or extra writebacks
	int valueErrors;	// Wrong id or value
	int tErrors;
	logic expectedT;

	// Last driven micro-op, applied once its flush is known
	logic pendValid;
	logic [cmdWidth-1:0] pendCmd;
	logic [ixtWidth-1:0] pendIxt;
	regIdT pendRs;
	regIdT pendRt;
	regIdT pendRm;
	laneWordT pendImm;

	laneTop #(
		.memDepth(memDepth)
	) u_laneTop (
		.clock(clock),
		.reset(reset),
		.issueValid(issueValid),
		.issueCmd(issueCmd),
		.issueIxt(issueIxt),
		.issueRs(issueRs),
		.issueRt(issueRt),
		.issueRm(issueRm),
		.issueImm(issueImm),
		.flush(flush),
		.wbValid(wbValid),
		.wbId(wbId),
		.wbValue(wbValue),
		.srT(srT)
	);

	always #50 clock = ~clock;	// 100 ns period

	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;	// Taps 16 14 13 11
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit
	function automatic int unsigned drawBits(input int count);
		int unsigned bits;
		bits = 0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return bits;
	endfunction

	// Settle the previous micro-op, then drive the next one
	task automatic issueCycle(input logic valid, input logic [cmdWidth-1:0] cmd,
		input logic [ixtWidth-1:0] ixt, input regIdT rs, input regIdT rt, input regIdT rm,
		input laneWordT imm, input logic kill);
		if (pendValid) begin
			applyOp(pendCmd, pendIxt, pendRs, pendRt, pendRm, pendImm, kill, cycle + 3, memDepth);
		end
		flush <= kill;	// Hits the micro-op now in EX1
		issueValid <= valid;
		issueCmd <= cmd;
		issueIxt <= ixt;
		issueRs <= rs;
		issueRt <= rt;
		issueRm <= rm;
		issueImm <= imm;
		pendValid = valid;
		pendCmd = cmd;
		pendIxt = ixt;
		pendRs = rs;
		pendRt = rt;
		pendRm = rm;
		pendImm = imm;
	endtask

	task automatic randomCycle();
		logic valid;
		int unsigned opCode;
		uOpT op;
		logic [1:0] pred;
		int unsigned fnBits;
		logic [ixtWidth-1:0] fn;
		logic kill;
		valid = drawBits(2) != 0;	// Three in four
		opCode = drawBits(3);
		op = (opCode == 7) ? UOP_ALU3 : uOpT'(opCode[5:0]);
		pred = 2'(drawBits(2));
		fnBits = drawBits(3);
		if (op == UOP_ALUCMP) begin
			fn = fnBits[0] ? CMP_GT : CMP_EQ;
		end else begin
			fn = 3'(fnBits % 5);	// ADD through XOR
		end
		issueCycle(valid, {pred, op}, fn, regIdT'(drawBits(4)), regIdT'(drawBits(4)),
			regIdT'(drawBits(4)), laneWordT'(drawBits(8)), drawBits(4) == 0);
	endtask

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= cycleLimit) begin
			$display("timeout after %0d cycles with writebacks still pending", cycle);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clock) begin
		wbEntryT expected;
		if (!reset) begin
			if (wbQueue.size() != 0 && wbQueue[0].due == cycle) begin
				expected = wbQueue.pop_front();
				assert (wbValid === 1'b1) else begin
					wbErrors++;
					$display("writeback of register %h missing at cycle %0d", expected.id, cycle);
				end
				assert (wbId === expected.id) else begin
					valueErrors++;
					$display("error wbId: got %h, expected %h", wbId, expected.id);
				end
				assert (wbValue === expected.value) else begin
					valueErrors++;
					$display("error wbValue: got %h, expected %h", wbValue, expected.value);
				end
			end else begin
				assert (wbValid === 1'b0) else begin
					wbErrors++;
					$display("writeback at cycle %0d that no micro-op should make", cycle);
				end
			end
			if (tQueue.size() != 0 && tQueue[0].due == cycle) begin
				expectedT = tQueue[0].t;
				void'(tQueue.pop_front());
			end
			assert (srT === expectedT) else begin
				tErrors++;
				$display("error srT: got %h, expected %h", srT, expectedT);
			end
		end
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		issueValid = 1'b0;
		issueCmd = '0;
		issueIxt = '0;
		issueRs = '0;
		issueRt = '0;
		issueRm = '0;
		issueImm = '0;
		flush = 1'b0;
		lfsrState = 16'd13;	// Seed
		cycle = 0;
		wbErrors = 0;
		valueErrors = 0;
		tErrors = 0;
		expectedT = 1'b0;
		pendValid = 1'b0;
		modelReset();
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;
		// OR of each register with its predecessor, all must read zero
		for (int i = 0; i < directedOps; i++) begin
			@(posedge clock);
			issueCycle(1'b1, {PRED_ALWAYS, UOP_ALU3}, ALU_OR, regIdT'(i),
				regIdT'((i + regCount - 1) % regCount), regIdT'(i), '0, 1'b0);
		end
		for (int i = 0; i < randomOps; i++) begin
			@(posedge clock);
			randomCycle();
		end
		@(posedge clock);
		issueCycle(1'b0, '0, '0, '0, '0, '0, '0, 1'b0);	// Flush decision for the last one
		while (wbQueue.size() != 0 || tQueue.size() != 0) begin
			@(posedge clock);
		end
		@(posedge clock);	// One more idle falling-edge check
		$display("writeback errors %0d, value errors %0d, T errors %0d",
			wbErrors, valueErrors, tErrors);
		if (wbErrors + valueErrors + tErrors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== bench/laneModelPkg.sv ====
package laneModelPkg;

	import lanePkg::*;

	// One expected commit on the writeback port
	typedef struct {
		int due;	// Cycle count at the checking negedge
		regIdT id;
		laneWordT value;
	} wbEntryT;

	// One expected change of the T bit
	typedef struct {
		int due;
		logic t;
	} tEntryT;

	laneWordT regs [regCount];	// Architectural registers
	laneWordT mem [int];	// Sparse, absent words read zero
	logic modelT;	// T after the newest applied micro-op
	wbEntryT wbQueue [$];	// In issue order
	tEntryT tQueue [$];

	function automatic void modelReset();
		foreach (regs[i]) begin
			regs[i] = '0;
		end
		mem.delete();
		modelT = 1'b0;
		wbQueue.delete();
		tQueue.delete();
	endfunction

	function automatic logic predicateHolds(input predT pred, input logic t);
		case (pred)
			PRED_ALWAYS: return 1'b1;
			PRED_NEVER: return 1'b0;
			PRED_IF_T: return t;
			default: return !t;	// If not T
		endcase
	endfunction

	function automatic laneWordT aluResult(input aluFnT fn, input laneWordT a, input laneWordT b);
		case (fn)
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR: return a | b;
			ALU_XOR: return a ^ b;
			default: return a + b;
		endcase
	endfunction

	function automatic void writeReg(input regIdT id, input laneWordT value, input int due);
		regs[id] = value;
		wbQueue.push_back(wbEntryT'{due: due, id: id, value: value});
	endfunction

	// Apply one issued micro-op in program order
	function automatic void applyOp(input logic [cmdWidth-1:0] cmd, input logic [ixtWidth-1:0] ixt,
		input regIdT rs, input regIdT rt, input regIdT rm, input laneWordT imm,
		input logic flushed, input int due, input int depth);
		uOpT op;
		laneWordT a;
		laneWordT b;
		int addr;
		op = uOpT'(cmd[5:0]);
		if (flushed || !predicateHolds(predT'(cmd[7:6]), modelT)) begin
			return;	// Squashed, no state changes
		end
		a = regs[rs];
		b = regs[rt];
		addr = int'((a + imm) % depth);	// Word index wraps
		case (op)
			UOP_MOV_IR: writeReg(rm, imm, due);
			UOP_ALU3: writeReg(rm, aluResult(aluFnT'(ixt), a, b), due);
			UOP_MULW3: writeReg(rm, a * b, due);	// Low word, sign does not matter
			UOP_MOV_MR: writeReg(rm, mem.exists(addr) ? mem[addr] : '0, due);
			UOP_MOV_RM: mem[addr] = regs[rm];
			UOP_ALUCMP: begin
				modelT = (ixt == CMP_GT) ? ($signed(a) > $signed(b)) : (a == b);
				tQueue.push_back(tEntryT'{due: due, t: modelT});
			end
			default: ;
		endcase
	endfunction

endpackage

// ==== rtl/laneTop.sv ====
module laneTop import lanePkg::*; #(
	parameter int memDepth = 256	// Data memory words
) (
	input logic clock,
	input logic reset,
	input logic issueValid,
	input logic [cmdWidth-1:0] issueCmd,
	input logic [ixtWidth-1:0] issueIxt,
	input regIdT issueRs,
	input regIdT issueRt,
	input regIdT issueRm,
	input laneWordT issueImm,
	input logic flush,
	output logic wbValid,
	output regIdT wbId,
	output laneWordT wbValue,
	output logic srT
);

	localparam int addrWidth = $clog2(memDepth);

	regIdT readIdA;
	regIdT readIdB;
	laneWordT readValueA;
	laneWordT readValueB;
	logic memReadEnable;
	logic memWriteEnable;
	logic [addrWidth-1:0] memAddress;
	laneWordT memWriteData;
	laneWordT memReadData;	// Back to EX2

	exStageBus exBus();	// EX1 to EX2
	bypassBus fwdBus();	// EX2 and writeback to EX1

	laneRegFile u_laneRegFile (
		.clock(clock),
		.reset(reset),
		.writeEnable(wbValid),	// Commit from writeback register
		.writeId(wbId),
		.writeValue(wbValue),
		.readIdA(readIdA),
		.readIdB(readIdB),
		.readValueA(readValueA),
		.readValueB(readValueB)
	);

	laneExec1 #(
		.memDepth(memDepth)
	) u_laneExec1 (
		.clock(clock),
		.reset(reset),
		.issueValid(issueValid),
		.issueCmd(issueCmd),
		.issueIxt(issueIxt),
		.issueRs(issueRs),
		.issueRt(issueRt),
		.issueRm(issueRm),
		.issueImm(issueImm),
		.flush(flush),
		.readValueA(readValueA),
		.readValueB(readValueB),
		.committedT(srT),
		.readIdA(readIdA),
		.readIdB(readIdB),
		.memReadEnable(memReadEnable),
		.memWriteEnable(memWriteEnable),
		.memAddress(memAddress),
		.memWriteData(memWriteData),
		.exOut(exBus.source),
		.bypass(fwdBus.sink)
	);

	laneExec2 u_laneExec2 (
		.clock(clock),
		.reset(reset),
		.memReadData(memReadData),
		.wbValid(wbValid),
		.wbId(wbId),
		.wbValue(wbValue),
		.srT(srT),
		.exIn(exBus.sink),
		.bypass(fwdBus.source)
	);

	laneDataMem #(
		.memDepth(memDepth)
	) u_laneDataMem (
		.clock(clock),
		.readEnable(memReadEnable),
		.writeEnable(memWriteEnable),
		.address(memAddress),
		.writeData(memWriteData),
		.readData(memReadData)
	);

endmodule

// ==== rtl/laneExec2.sv ====
module laneExec2 import lanePkg::*; (
	input logic clock,
	input logic reset,
	input laneWordT memReadData,	// Load issued in EX1 last cycle
	output logic wbValid,
	output regIdT wbId,
	output laneWordT wbValue,
	output logic srT,	// Committed T status bit
	exStageBus.sink exIn,
	bypassBus.source bypass
);

	logic resultWrite;	// EX2 produces a register value
	laneWordT resultValue;
	laneWordT mulValue;	// Low word of the product
	logic tWrite;	// Compare commits this cycle

	assign mulValue = exIn.mulLoLo + (exIn.mulCross << halfWidth);	// Cross terms shifted up

	always_comb begin
		resultWrite = 1'b0;
		resultValue = exIn.aluValue;	// EX1 value by default
		case (exIn.uOp)
			UOP_MOV_IR, UOP_ALU3: begin
				resultWrite = exIn.valid;
			end
			UOP_MULW3: begin
				resultWrite = exIn.valid;
				resultValue = mulValue;
			end
			UOP_MOV_MR: begin
				resultWrite = exIn.valid;
				resultValue = memReadData;
			end
			default: ;	// Compare, store and NOP write nothing
		endcase
	end

	assign tWrite = exIn.valid && exIn.cmpWrite;

	assign bypass.ex2Valid = resultWrite;
	assign bypass.ex2Id = exIn.destId;
	assign bypass.ex2Value = resultValue;
	assign bypass.ex2TWrite = tWrite;
	assign bypass.ex2T = exIn.cmpT;
	assign bypass.wbValid = wbValid;	// Writeback register
	assign bypass.wbId = wbId;
	assign bypass.wbValue = wbValue;

	always_ff @(posedge clock) begin
		if (reset) begin
			wbValid <= 1'b0;
			srT <= 1'b0;
		end else begin
			wbValid <= resultWrite;
			if (tWrite) begin
				srT <= exIn.cmpT;
			end
		end
		wbId <= exIn.destId;
		wbValue <= resultValue;
	end

	// Operations without a destination never reach writeback
	noWriteOps: assert property (
		@(posedge clock) disable iff (reset)
		exIn.valid && (exIn.uOp inside {UOP_ALUCMP, UOP_MOV_RM, UOP_NOP}) |=> !wbValid
	) else $error("writeback from a non-writing uOp");

endmodule

// ==== rtl/laneExec1.sv ====
module laneExec1 import lanePkg::*; #(
	parameter int memDepth = 256,
	localparam int addrWidth = $clog2(memDepth)
) (
	input logic clock,
	input logic reset,
	input logic issueValid,
	input logic [cmdWidth-1:0] issueCmd,	// Predicate and operation
	input logic [ixtWidth-1:0] issueIxt,	// ALU sub-function
	input regIdT issueRs,	// Base or ALU source A
	input regIdT issueRt,	// ALU source B
	input regIdT issueRm,	// Destination or store data
	input laneWordT issueImm,
	input logic flush,	// Kills the micro-op in this stage
	input laneWordT readValueA,
	input laneWordT readValueB,
	input logic committedT,	// srT from EX2
	output regIdT readIdA,
	output regIdT readIdB,
	output logic memReadEnable,
	output logic memWriteEnable,
	output logic [addrWidth-1:0] memAddress,
	output laneWordT memWriteData,
	exStageBus.source exOut,
	bypassBus.sink bypass
);

	logic stageValid;	// Issue latched last edge
	logic [cmdWidth-1:0] stageCmd;
	logic [ixtWidth-1:0] stageIxt;
	regIdT stageRs;
	regIdT stageRt;
	regIdT stageRm;
	laneWordT stageImm;

	uOpT stageUOp;
	predT stagePred;
	aluFnT stageFn;
	logic currentT;	// T after all older micro-ops
	logic predPass;
	logic opEnable;	// Micro-op really executes
	laneWordT valueA;	// Bypassed operands
	laneWordT valueB;
	laneWordT memSum;	// Rs + imm
	laneWordT aluNext;
	logic cmpNext;

	// Newest producer wins
	function automatic laneWordT resolve(input regIdT id, input laneWordT fileValue);
		if (bypass.ex2Valid && (bypass.ex2Id == id)) begin
			return bypass.ex2Value;	// Previous micro-op
		end
		if (bypass.wbValid && (bypass.wbId == id)) begin
			return bypass.wbValue;	// Two back
		end
		return fileValue;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			stageValid <= 1'b0;
		end else begin
			stageValid <= issueValid;
		end
		stageCmd <= issueCmd;
		stageIxt <= issueIxt;
		stageRs <= issueRs;
		stageRt <= issueRt;
		stageRm <= issueRm;
		stageImm <= issueImm;
	end

	assign stageUOp = uOpT'(stageCmd[5:0]);
	assign stagePred = predT'(stageCmd[7:6]);
	assign stageFn = aluFnT'(stageIxt);
	assign currentT = bypass.ex2TWrite ? bypass.ex2T : committedT;	// Compare in EX2 first

	assign readIdA = stageRs;
	assign readIdB = (stageUOp == UOP_MOV_RM) ? stageRm : stageRt;	// Store data on port B

	always_comb begin
		valueA = resolve(readIdA, readValueA);
		valueB = resolve(readIdB, readValueB);
	end

	assign memSum = valueA + stageImm;

	always_comb begin
		case (stagePred)
			PRED_NEVER: predPass = 1'b0;
			PRED_IF_T: predPass = currentT;
			PRED_IF_NOT_T: predPass = !currentT;
			default: predPass = 1'b1;	// Always
		endcase
	end

	assign opEnable = stageValid && predPass && !flush;	// Flush overrides predicate

	always_comb begin
		aluNext = valueA + valueB;	// Unlisted codes add
		case (stageFn)
			ALU_SUB: aluNext = valueA - valueB;
			ALU_AND: aluNext = valueA & valueB;
			ALU_OR: aluNext = valueA | valueB;
			ALU_XOR: aluNext = valueA ^ valueB;
			default: ;
		endcase
		if (stageUOp == UOP_MOV_IR) begin
			aluNext = stageImm;
		end
		cmpNext = (stageFn == CMP_GT) ? ($signed(valueA) > $signed(valueB))
			: (valueA == valueB);
	end

	assign memReadEnable = opEnable && (stageUOp == UOP_MOV_MR);
	assign memWriteEnable = opEnable && (stageUOp == UOP_MOV_RM);
	assign memAddress = memSum[addrWidth-1:0];	// Wraps at memDepth
	assign memWriteData = valueB;	// Rm

	always_ff @(posedge clock) begin
		if (reset) begin
			exOut.valid <= 1'b0;
		end else begin
			exOut.valid <= opEnable;
		end
		exOut.uOp <= stageUOp;
		exOut.destId <= stageRm;
		exOut.aluValue <= aluNext;
		exOut.mulLoLo <= valueA[halfWidth-1:0] * valueB[halfWidth-1:0];
		exOut.mulCross <= valueA[halfWidth-1:0] * valueB[wordWidth-1:halfWidth]
			+ valueA[wordWidth-1:halfWidth] * valueB[halfWidth-1:0];
		exOut.cmpT <= cmpNext;
		exOut.cmpWrite <= (stageUOp == UOP_ALUCMP);
	end

	knownUOp: assert property (
		@(posedge clock) disable iff (reset)
		stageValid |-> isKnownUOp(stageUOp)
	) else $error("unknown uOp %h", stageCmd[5:0]);

endmodule

// ==== rtl/laneDataMem.sv ====
module laneDataMem import lanePkg::*; #(
	parameter int memDepth = 256,	// Words
	localparam int addrWidth = $clog2(memDepth)
) (
	input logic clock,
	input logic readEnable,	// Load in EX1
	input logic writeEnable,	// Store in EX1
	input logic [addrWidth-1:0] address,	// Word index
	input laneWordT writeData,
	output laneWordT readData	// Valid the cycle after the request
);

	laneWordT mem [memDepth];

	// Untouched words read as zero
	initial begin
		for (int i = 0; i < memDepth; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clock) begin
		if (writeEnable) begin
			mem[address] <= writeData;
		end
		if (readEnable) begin
			readData <= mem[address];	// Synchronous read
		end
	end

	// One micro-op per cycle gives one access per cycle
	singleAccess: assert property (
		@(posedge clock)
		readEnable |-> !writeEnable
	) else $error("load and store in the same cycle");

endmodule

// ==== rtl/laneRegFile.sv ====
module laneRegFile import lanePkg::*; (
	input logic clock,
	input logic reset,
	input logic writeEnable,	// From the writeback register
	input regIdT writeId,
	input laneWordT writeValue,
	input regIdT readIdA,	// Rs side
	input regIdT readIdB,	// Rt or Rm side
	output laneWordT readValueA,
	output laneWordT readValueB
);

	laneWordT regs [regCount];	// Architectural registers

	// Write-first read of one port
	function automatic laneWordT readPort(input regIdT id);
		if (writeEnable && (writeId == id)) begin
			return writeValue;	// Value being committed now
		end
		return regs[id];
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;	// All registers start at zero
			end
		end else if (writeEnable) begin
			regs[writeId] <= writeValue;
		end
	end

	always_comb begin
		readValueA = readPort(readIdA);	// Asynchronous
		readValueB = readPort(readIdB);
	end

	// A commit must name a real register
	writeIdKnown: assert property (
		@(posedge clock) disable iff (reset)
		writeEnable |-> !$isunknown(writeId)
	) else $error("register write with unknown id");

endmodule

// ==== rtl/bypassBus.sv ====
interface bypassBus import lanePkg::*; ();

	logic ex2Valid;	// EX2 writes a register this cycle
	regIdT ex2Id;
	laneWordT ex2Value;	// Combinational EX2 result
	logic ex2TWrite;	// Compare in EX2
	logic ex2T;	// Its outcome

	logic wbValid;	// Writeback register holds a value
	regIdT wbId;
	laneWordT wbValue;

	modport source(
		output ex2Valid, ex2Id, ex2Value, ex2TWrite, ex2T,
		output wbValid, wbId, wbValue
	);

	modport sink(
		input ex2Valid, ex2Id, ex2Value, ex2TWrite, ex2T,
		input wbValid, wbId, wbValue
	);

endinterface

// ==== rtl/exStageBus.sv ====
interface exStageBus import lanePkg::*; ();

	logic valid;	// Passed predicate and not flushed
	uOpT uOp;	// Operation in EX2
	regIdT destId;	// Rm of the micro-op
	laneWordT aluValue;	// ALU result or immediate
	laneWordT mulLoLo;	// Low half times low half
	laneWordT mulCross;	// Sum of both cross products
	logic cmpT;	// Compare outcome
	logic cmpWrite;	// Compare wants to update T

	// EX1 stage register side
	modport source(
		output valid, uOp, destId, aluValue,
		output mulLoLo, mulCross, cmpT, cmpWrite
	);

	// EX2 side
	modport sink(
		input valid, uOp, destId, aluValue,
		input mulLoLo, mulCross, cmpT, cmpWrite
	);

endinterface

// ==== rtl/lanePkg.sv ====
package lanePkg;

	localparam int wordWidth = 32;	// Datapath width
	localparam int halfWidth = wordWidth / 2;	// Multiply split point
	localparam int regCount = 16;	// Architectural registers
	localparam int regIdWidth = $clog2(regCount);
	localparam int cmdWidth = 8;	// Predicate plus operation
	localparam int ixtWidth = 3;	// ALU sub-function field

	typedef logic [wordWidth-1:0] laneWordT;	// One data word
	typedef logic [regIdWidth-1:0] regIdT;	// Register index

	// Low six bits of the command
	typedef enum logic [5:0] {
		UOP_NOP = 6'h00,	// Does nothing
		UOP_MOV_IR = 6'h01,	// Rm gets immediate
		UOP_ALU3 = 6'h02,	// Rm gets Rs op Rt
		UOP_ALUCMP = 6'h03,	// T gets Rs cmp Rt
		UOP_MULW3 = 6'h04,	// Rm gets low word of Rs*Rt
		UOP_MOV_RM = 6'h05,	// Store Rm at Rs+imm
		UOP_MOV_MR = 6'h06	// Rm gets load from Rs+imm
	} uOpT;

	// Meaning depends on the operation
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,	// ALU3 sum
		ALU_SUB = 3'd1,	// ALU3 difference
		ALU_AND = 3'd2,
		ALU_OR = 3'd3,
		ALU_XOR = 3'd4,
		CMP_EQ = 3'd5,	// ALUCMP equal
		CMP_GT = 3'd6	// ALUCMP signed greater
	} aluFnT;

	// Top two bits of the command
	typedef enum logic [1:0] {
		PRED_ALWAYS = 2'd0,	// Unconditional
		PRED_NEVER = 2'd1,	// Squashed
		PRED_IF_T = 2'd2,	// Runs when T set
		PRED_IF_NOT_T = 2'd3	// Runs when T clear
	} predT;

	// Enumerated operation check
	function automatic logic isKnownUOp(input uOpT op);
		return op inside {
			UOP_NOP,
			UOP_MOV_IR,
			UOP_ALU3,
			UOP_ALUCMP,
			UOP_MULW3,
			UOP_MOV_RM,
			UOP_MOV_MR
		};
	endfunction

endpackage
